// ==== pwconv.f ====
verilog/pwconv_pkg.sv
verilog/pwconv_pixel_counter.sv
verilog/pwconv_mem_img.sv
verilog/pwconv_mem_net.sv
verilog/pwconv_accum.sv
verilog/pwconv_ctrl_core.sv
verilog/pwconv_top.sv
test/pwconv_tb.sv

// ==== Bender.yml ====
package:
  name: pwconv

sources:
  - files:
      - verilog/pwconv_pkg.sv
      - verilog/pwconv_pixel_counter.sv
      - verilog/pwconv_mem_img.sv
      - verilog/pwconv_mem_net.sv
      - verilog/pwconv_accum.sv
      - verilog/pwconv_ctrl_core.sv
      - verilog/pwconv_top.sv
  - target: test
    files:
      - test/pwconv_tb.sv

// ==== test/pwconv_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwconv_tb;

  import pwconv_pkg::*;

  localparam int TIMEOUT   = 20000;
  localparam int IMG_WORDS = 2**IMGSIZE;
  localparam int NET_WORDS = 2**NETSIZE;
  // region a stray req would write if it were taken
  localparam int DECOY_OUT = 3584;

  logic                     clk;
  logic                     xrst;
  logic                     req;
  logic [LWIDTH-1:0]        total_in;
  logic [LWIDTH-1:0]        total_out;
  logic [LWIDTH-1:0]        img_size;
  logic [IMGSIZE-1:0]       in_offset;
  logic [IMGSIZE-1:0]       out_offset;
  logic [NETSIZE-1:0]       net_offset;
  logic                     img_we;
  logic [IMGSIZE-1:0]       img_addr;
  logic signed [DWIDTH-1:0] img_wdata;
  logic                     net_we;
  logic [NETSIZE-1:0]       net_addr;
  logic signed [DWIDTH-1:0] net_wdata;
  wire                      ack;
  core_state_t              core_state;
  wire signed [DWIDTH-1:0]  img_rdata;

  logic signed [DWIDTH-1:0] img_shadow [IMG_WORDS];
  logic signed [DWIDTH-1:0] net_shadow [NET_WORDS];
  logic [31:0]              seed;
  int                       errors;
  int                       total_errors;
  int                       failed_tests;
  int                       test_count;

  pwconv_top uut (
    .clk        (clk),
    .xrst       (xrst),
    .req        (req),
    .total_in   (total_in),
    .total_out  (total_out),
    .img_size   (img_size),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .img_we     (img_we),
    .img_addr   (img_addr),
    .img_wdata  (img_wdata),
    .net_we     (net_we),
    .net_addr   (net_addr),
    .net_wdata  (net_wdata),
    .ack        (ack),
    .core_state (core_state),
    .img_rdata  (img_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

//======================================================================
// stimulus helpers
//======================================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    seed = xorshift32(seed);
    return seed % n;
  endfunction

  task automatic fill_image();
    logic signed [DWIDTH-1:0] d;
    int a;
    for (a = 0; a < IMG_WORDS; a++) begin
      d = DWIDTH'(rand_below(32'h10000));
      @(negedge clk);
      img_we    = 1'b1;
      img_addr  = IMGSIZE'(a);
      img_wdata = d;
      img_shadow[a] = d;
    end
    @(negedge clk);
    img_we = 1'b0;
  endtask

  // weights of one output channel, then its bias
  task automatic load_weights(input int n_in, input int n_out, input int net_off);
    logic signed [DWIDTH-1:0] w;
    int k;
    int a;
    for (k = 0; k < n_out * (n_in + 1); k++) begin
      a = (net_off + k) % NET_WORDS;
      w = DWIDTH'(rand_below(32'h10000));
      @(negedge clk);
      net_we    = 1'b1;
      net_addr  = NETSIZE'(a);
      net_wdata = w;
      net_shadow[a] = w;
    end
    @(negedge clk);
    net_we = 1'b0;
  endtask

  task automatic read_img(input int addr, output logic signed [DWIDTH-1:0] data);
    @(negedge clk);
    img_addr = IMGSIZE'(addr);
    @(negedge clk);
    data = img_rdata;
  endtask

  task automatic wait_ack(input logic level);
    int cnt;
    cnt = 0;
    while (ack !== level && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (ack !== level) begin
      $display("timeout: ack did not go to %b within %0d cycles", level, TIMEOUT);
      $display("TB FAILED");
      $finish;
    end
  endtask

//======================================================================
// reference model
//======================================================================

  task automatic apply_model(input int n_in, input int n_out, input int size,
                             input int in_off, input int out_off, input int net_off);
    longint sum;
    int plane;
    int wbase;
    int o;
    int p;
    int i;
    plane = size * size;
    for (o = 0; o < n_out; o++) begin
      wbase = net_off + o * (n_in + 1);
      for (p = 0; p < plane; p++) begin
        sum = longint'(net_shadow[(wbase + n_in) % NET_WORDS]) <<< FRAC_BITS;
        for (i = 0; i < n_in; i++)
          sum += longint'(net_shadow[(wbase + i) % NET_WORDS]) *
                 longint'(img_shadow[(in_off + i * plane + p) % IMG_WORDS]);
        sum = sum >>> FRAC_BITS;
        img_shadow[(out_off + o * plane + p) % IMG_WORDS] = DWIDTH'(sum);
      end
    end
  endtask

  task automatic run_layer(input int n_in, input int n_out, input int size,
                           input int in_off, input int out_off, input int net_off,
                           input bit decoy);
    @(negedge clk);
    req        = 1'b1;
    total_in   = LWIDTH'(n_in);
    total_out  = LWIDTH'(n_out);
    img_size   = LWIDTH'(size);
    in_offset  = IMGSIZE'(in_off);
    out_offset = IMGSIZE'(out_off);
    net_offset = NETSIZE'(net_off);
    @(negedge clk);
    req = 1'b0;
    wait_ack(1'b0);
    if (decoy) begin
      repeat (3) @(negedge clk);
      req        = 1'b1;
      total_in   = LWIDTH'(1);
      total_out  = LWIDTH'(2);
      img_size   = LWIDTH'(16);
      in_offset  = '0;
      out_offset = IMGSIZE'(DECOY_OUT);
      net_offset = '0;
      @(negedge clk);
      req = 1'b0;
    end
    wait_ack(1'b1);
    apply_model(n_in, n_out, size, in_off, out_off, net_off);
  endtask

//======================================================================
// checks
//======================================================================

  task automatic check_region(input string name, input int start, input int len);
    logic signed [DWIDTH-1:0] got;
    int k;
    int a;
    for (k = 0; k < len; k++) begin
      a = (start + k) % IMG_WORDS;
      read_img(a, got);
      if (got !== img_shadow[a]) begin
        $display("Fail %s addr %0d: expected %h actual %h", name, a, img_shadow[a], got);
        errors++;
      end
    end
  endtask

  task automatic report_test(input string name);
    test_count++;
    total_errors += errors;
    if (errors == 0)
      $display("test %0d %s: ok", test_count, name);
    else begin
      $display("test %0d %s: %0d errors", test_count, name, errors);
      failed_tests++;
    end
    errors = 0;
  endtask

  initial begin
    int n_in;
    int n_out;
    int size;
    int in_off;
    int out_off;
    int net_off;
    int out_b;
    int net_b;
    int k;
    seed         = 32'hee976323;
    errors       = 0;
    total_errors = 0;
    failed_tests = 0;
    test_count   = 0;
    xrst       = 1'b0;
    req        = 1'b0;
    total_in   = '0;
    total_out  = '0;
    img_size   = '0;
    in_offset  = '0;
    out_offset = '0;
    net_offset = '0;
    img_we     = 1'b0;
    img_addr   = '0;
    img_wdata  = '0;
    net_we     = 1'b0;
    net_addr   = '0;
    net_wdata  = '0;
    repeat (2) @(negedge clk);
    xrst = 1'b1;
    @(negedge clk);

    if (ack !== 1'b1) begin
      $display("Fail reset_idle ack: expected 1 actual %b", ack);
      errors++;
    end
    if (core_state !== S_WAIT) begin
      $display("Fail reset_idle state: expected %0d actual %0d", S_WAIT, core_state);
      errors++;
    end
    report_test("reset_idle");

    fill_image();

    // single channel in and out
    size    = 1 + rand_below(16);
    in_off  = rand_below(512);
    out_off = 1536 + rand_below(512);
    net_off = rand_below(1000);
    load_weights(1, 1, net_off);
    run_layer(1, 1, size, in_off, out_off, net_off, 1'b0);
    check_region("single_channel", out_off, size * size);
    report_test("single_channel");

    for (k = 0; k < 4; k++) begin
      n_in    = 1 + rand_below(4);
      n_out   = 1 + rand_below(4);
      size    = 1 + rand_below(16);
      in_off  = rand_below(512);
      out_off = 1536 + rand_below(512);
      net_off = rand_below(1000);
      load_weights(n_in, n_out, net_off);
      run_layer(n_in, n_out, size, in_off, out_off, net_off, 1'b0);
      check_region("random_layer", out_off, n_out * size * size);
    end
    report_test("random_layer");

    check_region("untouched_memory", 0, IMG_WORDS);
    report_test("untouched_memory");

    n_in    = 1 + rand_below(4);
    n_out   = 1 + rand_below(4);
    size    = 1 + rand_below(16);
    in_off  = rand_below(512);
    out_off = 1536 + rand_below(512);
    net_off = rand_below(1000);
    load_weights(n_in, n_out, net_off);
    run_layer(n_in, n_out, size, in_off, out_off, net_off, 1'b1);
    // a taken second req would drop ack again
    repeat (4) begin
      @(negedge clk);
      if (ack !== 1'b1) begin
        $display("Fail busy_req ack: expected 1 actual %b", ack);
        errors++;
      end
    end
    check_region("busy_req", out_off, n_out * size * size);
    check_region("busy_req_decoy", DECOY_OUT, 512);
    report_test("busy_req");

    // second layer reads the planes of the first
    n_in    = 1 + rand_below(4);
    n_out   = 1 + rand_below(4);
    size    = 1 + rand_below(16);
    in_off  = rand_below(512);
    out_off = 1536 + rand_below(256);
    out_b   = 2816 + rand_below(256);
    net_off = rand_below(480);
    net_b   = 512 + rand_below(480);
    k       = 1 + rand_below(4);
    load_weights(n_in, n_out, net_off);
    load_weights(n_out, k, net_b);
    run_layer(n_in, n_out, size, in_off, out_off, net_off, 1'b0);
    run_layer(n_out, k, size, out_off, out_b, net_b, 1'b0);
    check_region("chained_layers", out_off, n_out * size * size);
    check_region("chained_layers", out_b, k * size * size);
    report_test("chained_layers");

    $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, total_errors);
    if (failed_tests == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/pwconv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwconv_top (
  input  wire                                 clk,
  input  wire                                 xrst,
  input  wire                                 req,
  input  wire [pwconv_pkg::LWIDTH-1:0]        total_in,
  input  wire [pwconv_pkg::LWIDTH-1:0]        total_out,
  input  wire [pwconv_pkg::LWIDTH-1:0]        img_size,
  input  wire [pwconv_pkg::IMGSIZE-1:0]       in_offset,
  input  wire [pwconv_pkg::IMGSIZE-1:0]       out_offset,
  input  wire [pwconv_pkg::NETSIZE-1:0]       net_offset,
  input  wire                                 img_we,
  input  wire [pwconv_pkg::IMGSIZE-1:0]       img_addr,
  input  wire signed [pwconv_pkg::DWIDTH-1:0] img_wdata,
  input  wire                                 net_we,
  input  wire [pwconv_pkg::NETSIZE-1:0]       net_addr,
  input  wire signed [pwconv_pkg::DWIDTH-1:0] net_wdata,
  output wire                                 ack,
  output pwconv_pkg::core_state_t             core_state,
  output wire signed [pwconv_pkg::DWIDTH-1:0] img_rdata
);

  import pwconv_pkg::*;

  wire                      run;
  wire [LWIDTH-1:0]         layer_size;
  wire [PIXLOG-1:0]         pix_idx;
  wire                      plane_end;
  wire                      mem_img_we;
  wire [IMGSIZE-1:0]        mem_img_addr;
  wire signed [DWIDTH-1:0]  mem_img_wdata;
  wire [NETSIZE-1:0]        net_raddr;
  wire signed [DWIDTH-1:0]  net_rdata;
  wire                      w_load;
  wire                      b_load;
  wire                      pix_en;
  wire                      first_input;
  wire [PIXLOG-1:0]         acc_idx;
  wire                      out_en;
  wire signed [DWIDTH-1:0]  result;

  pwconv_ctrl_core u_core (
    .clk            (clk),
    .xrst           (xrst),
    .req            (req),
    .total_in       (total_in),
    .total_out      (total_out),
    .img_size       (img_size),
    .in_offset      (in_offset),
    .out_offset     (out_offset),
    .net_offset     (net_offset),
    .host_img_we    (img_we),
    .host_img_addr  (img_addr),
    .host_img_wdata (img_wdata),
    .plane_end      (plane_end),
    .pix_idx        (pix_idx),
    .result         (result),
    .ack            (ack),
    .core_state     (core_state),
    .run            (run),
    .layer_size     (layer_size),
    .mem_img_we     (mem_img_we),
    .mem_img_addr   (mem_img_addr),
    .mem_img_wdata  (mem_img_wdata),
    .net_raddr      (net_raddr),
    .w_load         (w_load),
    .b_load         (b_load),
    .pix_en         (pix_en),
    .first_input    (first_input),
    .acc_idx        (acc_idx),
    .out_en         (out_en)
  );

  // plane size comes from the latched layer, not the host inputs
  pwconv_pixel_counter u_counter (
    .clk       (clk),
    .xrst      (xrst),
    .run       (run),
    .img_size  (layer_size),
    .pix_idx   (pix_idx),
    .plane_end (plane_end)
  );

  pwconv_mem_img u_mem_img (
    .clk   (clk),
    .we    (mem_img_we),
    .addr  (mem_img_addr),
    .wdata (mem_img_wdata),
    .rdata (img_rdata)
  );

  pwconv_mem_net u_mem_net (
    .clk   (clk),
    .we    (net_we),
    .waddr (net_addr),
    .wdata (net_wdata),
    .raddr (net_raddr),
    .rdata (net_rdata)
  );

  pwconv_accum u_accum (
    .clk         (clk),
    .xrst        (xrst),
    .w_load      (w_load),
    .b_load      (b_load),
    .net_rdata   (net_rdata),
    .pix_en      (pix_en),
    .first_input (first_input),
    .acc_idx     (acc_idx),
    .pix_data    (img_rdata),
    .out_en      (out_en),
    .result      (result)
  );

endmodule

`default_nettype wire

// ==== verilog/pwconv_ctrl_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwconv_ctrl_core (
  input  wire                                  clk,
  input  wire                                  xrst,
  input  wire                                  req,
  input  wire [pwconv_pkg::LWIDTH-1:0]         total_in,
  input  wire [pwconv_pkg::LWIDTH-1:0]         total_out,
  input  wire [pwconv_pkg::LWIDTH-1:0]         img_size,
  input  wire [pwconv_pkg::IMGSIZE-1:0]        in_offset,
  input  wire [pwconv_pkg::IMGSIZE-1:0]        out_offset,
  input  wire [pwconv_pkg::NETSIZE-1:0]        net_offset,
  input  wire                                  host_img_we,
  input  wire [pwconv_pkg::IMGSIZE-1:0]        host_img_addr,
  input  wire signed [pwconv_pkg::DWIDTH-1:0]  host_img_wdata,
  input  wire                                  plane_end,
  input  wire [pwconv_pkg::PIXLOG-1:0]         pix_idx,
  input  wire signed [pwconv_pkg::DWIDTH-1:0]  result,
  output logic                                 ack,
  output pwconv_pkg::core_state_t              core_state,
  output logic                                 run,
  output logic [pwconv_pkg::LWIDTH-1:0]        layer_size,
  output logic                                 mem_img_we,
  output logic [pwconv_pkg::IMGSIZE-1:0]       mem_img_addr,
  output logic signed [pwconv_pkg::DWIDTH-1:0] mem_img_wdata,
  output logic [pwconv_pkg::NETSIZE-1:0]       net_raddr,
  output logic                                 w_load,
  output logic                                 b_load,
  output logic                                 pix_en,
  output logic                                 first_input,
  output logic [pwconv_pkg::PIXLOG-1:0]        acc_idx,
  output logic                                 out_en
);

  import pwconv_pkg::*;

  core_state_t        r_state;
  weight_state_t      r_wstate;
  logic               r_ack;
  logic [LWIDTH-1:0]  r_total_in;
  logic [LWIDTH-1:0]  r_total_out;
  logic [LWIDTH-1:0]  r_img_size;
  logic [LWIDTH-1:0]  r_count_in;
  logic [LWIDTH-1:0]  r_count_out;
  logic [IMGSIZE-1:0] r_plane;
  logic [IMGSIZE-1:0] r_in_offset;
  logic [IMGSIZE-1:0] r_in_base;
  logic [IMGSIZE-1:0] r_out_base;
  logic [NETSIZE-1:0] r_net_addr;
  logic [1:0]         r_drain;
  logic               r_w_load;
  logic               r_b_load;
  logic               r_pix_en;
  logic               r_first;
  logic               r_out_en;
  logic               r_wr_en;
  logic [PIXLOG-1:0]  r_idx_d;
  logic [IMGSIZE-1:0] r_out_addr_d;
  logic [IMGSIZE-1:0] r_wr_addr;
  logic               accept;
  logic               last_in;
  logic               last_out;
  logic               s_network_end;
  logic               s_input_end;
  logic               s_output_end;

//======================================================================
// layer control
//======================================================================

  assign accept   = r_state == S_WAIT && req;
  assign last_in  = r_count_in == r_total_in - LWIDTH'(1);
  assign last_out = r_count_out == r_total_out - LWIDTH'(1);

  // bias read adds a second cycle on the last input channel
  assign s_network_end = r_state == S_NETWORK && (r_wstate == S_W_BIAS || !last_in);
  assign s_input_end   = r_state == S_INPUT && plane_end;
  assign s_output_end  = r_state == S_OUTPUT && r_drain == 2'd2;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state     <= S_WAIT;
      r_count_in  <= '0;
      r_count_out <= '0;
    end else begin
      case (r_state)
        S_WAIT:
          if (accept)
            r_state <= S_NETWORK;
        S_NETWORK:
          if (s_network_end)
            r_state <= S_INPUT;
        S_INPUT:
          if (s_input_end) begin
            if (last_in) begin
              r_state    <= S_OUTPUT;
              r_count_in <= '0;
            end else begin
              r_state    <= S_NETWORK;
              r_count_in <= r_count_in + LWIDTH'(1);
            end
          end
        S_OUTPUT:
          if (s_output_end) begin
            if (last_out) begin
              r_state     <= S_WAIT;
              r_count_out <= '0;
            end else begin
              r_state     <= S_NETWORK;
              r_count_out <= r_count_out + LWIDTH'(1);
            end
          end
        default:
          r_state <= S_WAIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      r_ack <= 1'b1;
    else if (accept)
      r_ack <= 1'b0;
    else if (s_output_end && last_out)
      r_ack <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_total_in  <= '0;
      r_total_out <= '0;
      r_img_size  <= '0;
      r_plane     <= '0;
      r_in_offset <= '0;
    end else if (accept) begin
      r_total_in  <= total_in;
      r_total_out <= total_out;
      r_img_size  <= img_size;
      r_plane     <= img_size * img_size;
      r_in_offset <= in_offset;
    end
  end

  // plane bases, input restarts for every output channel
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_in_base  <= '0;
      r_out_base <= '0;
    end else if (accept) begin
      r_in_base  <= in_offset;
      r_out_base <= out_offset;
    end else begin
      if (s_input_end)
        r_in_base <= last_in ? r_in_offset : r_in_base + r_plane;
      if (s_output_end)
        r_out_base <= r_out_base + r_plane;
    end
  end

  // 0 while streaming, then two drain cycles
  always_ff @(posedge clk) begin
    if (!xrst)
      r_drain <= 2'd0;
    else if (r_state == S_OUTPUT) begin
      if (r_drain == 2'd0) begin
        if (plane_end)
          r_drain <= 2'd1;
      end else if (r_drain == 2'd1)
        r_drain <= 2'd2;
      else
        r_drain <= 2'd0;
    end
  end

  assign run        = r_state == S_INPUT || (r_state == S_OUTPUT && r_drain == 2'd0);
  assign ack        = r_ack;
  assign core_state = r_state;
  assign layer_size = r_img_size;

//======================================================================
// network control
//======================================================================

  always_ff @(posedge clk) begin
    if (!xrst)
      r_wstate <= S_W_WEIGHT;
    else if (r_state == S_NETWORK) begin
      if (r_wstate == S_W_WEIGHT && last_in)
        r_wstate <= S_W_BIAS;
      else
        r_wstate <= S_W_WEIGHT;
    end
  end

  // weights and biases sit back to back per output channel
  always_ff @(posedge clk) begin
    if (!xrst)
      r_net_addr <= '0;
    else if (accept)
      r_net_addr <= net_offset;
    else if (r_state == S_NETWORK)
      r_net_addr <= r_net_addr + NETSIZE'(1);
  end

  assign net_raddr = r_net_addr;

//======================================================================
// pixel pipeline
//======================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_w_load <= 1'b0;
      r_b_load <= 1'b0;
      r_pix_en <= 1'b0;
      r_first  <= 1'b0;
      r_out_en <= 1'b0;
      r_wr_en  <= 1'b0;
    end else begin
      r_w_load <= r_state == S_NETWORK && r_wstate == S_W_WEIGHT;
      r_b_load <= r_state == S_NETWORK && r_wstate == S_W_BIAS;
      r_pix_en <= r_state == S_INPUT;
      r_first  <= r_state == S_INPUT && r_count_in == '0;
      r_out_en <= r_state == S_OUTPUT && r_drain == 2'd0;
      r_wr_en  <= r_out_en;
    end
  end

  always_ff @(posedge clk) begin
    r_idx_d      <= pix_idx;
    r_out_addr_d <= r_out_base + IMGSIZE'(pix_idx);
    r_wr_addr    <= r_out_addr_d;
  end

  assign w_load      = r_w_load;
  assign b_load      = r_b_load;
  assign pix_en      = r_pix_en;
  assign first_input = r_first;
  assign out_en      = r_out_en;
  assign acc_idx     = r_idx_d;

  // host owns the image port while idle
  always_comb begin
    case (r_state)
      S_WAIT: begin
        mem_img_we    = host_img_we;
        mem_img_addr  = host_img_addr;
        mem_img_wdata = host_img_wdata;
      end
      S_INPUT: begin
        mem_img_we    = 1'b0;
        mem_img_addr  = r_in_base + IMGSIZE'(pix_idx);
        mem_img_wdata = result;
      end
      default: begin
        mem_img_we    = r_wr_en;
        mem_img_addr  = r_wr_addr;
        mem_img_wdata = result;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/pwconv_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwconv_accum (
  input  wire                                  clk,
  input  wire                                  xrst,
  input  wire                                  w_load,
  input  wire                                  b_load,
  input  wire signed [pwconv_pkg::DWIDTH-1:0]  net_rdata,
  input  wire                                  pix_en,
  input  wire                                  first_input,
  input  wire [pwconv_pkg::PIXLOG-1:0]         acc_idx,
  input  wire signed [pwconv_pkg::DWIDTH-1:0]  pix_data,
  input  wire                                  out_en,
  output logic signed [pwconv_pkg::DWIDTH-1:0] result
);

  import pwconv_pkg::*;

  logic signed [DWIDTH-1:0]   r_weight;
  logic signed [DWIDTH-1:0]   r_bias;
  logic signed [ACCWIDTH-1:0] r_acc [MAX_PIX];
  logic signed [2*DWIDTH-1:0] product;
  logic signed [ACCWIDTH-1:0] acc_prev;
  logic signed [ACCWIDTH-1:0] out_sum;
  logic signed [ACCWIDTH-1:0] scaled_sum;

//======================================================================
// parameters
//======================================================================

  always_ff @(posedge clk) begin
    if (w_load)
      r_weight <= net_rdata;
    if (b_load)
      r_bias <= net_rdata;
  end

//======================================================================
// multiply-accumulate
//======================================================================

  assign product  = r_weight * pix_data;
  // first channel starts the pixel fresh
  assign acc_prev = first_input ? '0 : r_acc[acc_idx];

  always_ff @(posedge clk) begin
    if (pix_en)
      r_acc[acc_idx] <= acc_prev + product;
  end

//======================================================================
// output scaling
//======================================================================

  // bias is aligned to the product's fraction point
  assign out_sum    = r_acc[acc_idx] + (ACCWIDTH'(r_bias) <<< FRAC_BITS);
  assign scaled_sum = out_sum >>> FRAC_BITS;

  always_ff @(posedge clk) begin
    if (!xrst)
      result <= '0;
    else if (out_en)
      result <= scaled_sum[DWIDTH-1:0];
  end

endmodule

`default_nettype wire

// ==== verilog/pwconv_mem_net.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwconv_mem_net (
  input  wire                                  clk,
  input  wire                                  we,
  input  wire [pwconv_pkg::NETSIZE-1:0]        waddr,
  input  wire signed [pwconv_pkg::DWIDTH-1:0]  wdata,
  input  wire [pwconv_pkg::NETSIZE-1:0]        raddr,
  output logic signed [pwconv_pkg::DWIDTH-1:0] rdata
);

  import pwconv_pkg::*;

  logic signed [DWIDTH-1:0] r_mem [2**NETSIZE];

  always_ff @(posedge clk) begin
    if (we)
      r_mem[waddr] <= wdata;
  end

  // engine side
  always_ff @(posedge clk) begin
    rdata <= r_mem[raddr];
  end

endmodule

`default_nettype wire

// ==== verilog/pwconv_mem_img.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwconv_mem_img (
  input  wire                                  clk,
  input  wire                                  we,
  input  wire [pwconv_pkg::IMGSIZE-1:0]        addr,
  input  wire signed [pwconv_pkg::DWIDTH-1:0]  wdata,
  output logic signed [pwconv_pkg::DWIDTH-1:0] rdata
);

  import pwconv_pkg::*;

  logic signed [DWIDTH-1:0] r_mem [2**IMGSIZE];

  // read returns the old word on a write
  always_ff @(posedge clk) begin
    if (we)
      r_mem[addr] <= wdata;
    rdata <= r_mem[addr];
  end

endmodule

`default_nettype wire

// ==== verilog/pwconv_pixel_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwconv_pixel_counter (
  input  wire                           clk,
  input  wire                           xrst,
  input  wire                           run,
  input  wire [pwconv_pkg::LWIDTH-1:0]  img_size,
  output logic [pwconv_pkg::PIXLOG-1:0] pix_idx,
  output logic                          plane_end
);

  import pwconv_pkg::*;

  logic [LWIDTH-1:0] r_x;
  logic [LWIDTH-1:0] r_y;
  logic              x_end;
  logic              y_end;

  assign x_end     = r_x == img_size - LWIDTH'(1);
  assign y_end     = r_y == img_size - LWIDTH'(1);
  assign plane_end = run && x_end && y_end;

  // raster order, wraps so back to back planes need no gap
  always_ff @(posedge clk) begin
    if (!xrst || !run) begin
      r_x     <= '0;
      r_y     <= '0;
      pix_idx <= '0;
    end else begin
      if (x_end) begin
        r_x <= '0;
        r_y <= y_end ? '0 : r_y + LWIDTH'(1);
      end else
        r_x <= r_x + LWIDTH'(1);
      pix_idx <= plane_end ? '0 : pix_idx + PIXLOG'(1);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pwconv_pkg.sv ====
`default_nettype none

package pwconv_pkg;

  // data format
  localparam int DWIDTH    = 16;
  localparam int FRAC_BITS = 8;
  localparam int ACCWIDTH  = 40;

  // memory address widths
  localparam int IMGSIZE = 12;
  localparam int NETSIZE = 10;

  // layer size fields
  localparam int LWIDTH  = 8;
  localparam int MAX_PIX = 256;
  localparam int PIXLOG  = 8;

  typedef enum logic [1:0] {
    S_WAIT    = 2'd0,
    S_NETWORK = 2'd1,
    S_INPUT   = 2'd2,
    S_OUTPUT  = 2'd3
  } core_state_t;

  typedef enum logic {
    S_W_WEIGHT = 1'b0,
    S_W_BIAS   = 1'b1
  } weight_state_t;

endpackage

`default_nettype wire
